//--- verilog/des_pkg.sv
package des_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // table sizes
   // ~~~~~~~~~~~~~~~~~~~~

   localparam int GATE_ID_W = 10;
   localparam int N_GATES   = 1024;
   localparam int NBR_IDX_W = 12;
   localparam int N_NBRS    = 4096;

   // ~~~~~~~~~~~~~~~~~~~~
   // configuration map
   // ~~~~~~~~~~~~~~~~~~~~

   // bit 0 of the data selects the sequence-number timestamp format
   localparam logic [15:0] CFG_SEQ_EN      = 16'd52;
   localparam logic [15:0] CFG_GATE_BASE   = 16'h4000;
   // one word per gate, end index in the upper half and begin index in the lower half
   localparam logic [15:0] CFG_OFFSET_BASE = 16'h8000;
   localparam logic [15:0] CFG_NBR_BASE    = 16'hC000;

   // ~~~~~~~~~~~~~~~~~~~~
   // types
   // ~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0] {
      LOGIC_0,
      LOGIC_1,
      LOGIC_X,
      LOGIC_Z
   } logic_val_e;

   typedef enum logic [2:0] {
      BUF,
      INV,
      NAND2,
      NOR2,
      AND2,
      OR2,
      XOR2,
      XNOR2
   } gate_type_e;

   // broadcast events stand for primary inputs and skip evaluation
   typedef enum logic {
      EVT_INPUT,
      EVT_BROADCAST
   } task_type_e;

   typedef logic [GATE_ID_W-1:0] gate_id_t;

   typedef struct packed {
      logic [31:0] ts;
      gate_id_t    locale;
      task_type_e  ttype;
      logic_val_e  value;
      logic        port;
   } task_t;

   typedef struct packed {
      logic [5:0]  seq;
      logic_val_e  out_val;
      logic_val_e  in0_val;
      logic_val_e  in1_val;
      logic        reserved;
      gate_type_e  gtype;
      logic [15:0] delay;
   } gate_rec_t;

   typedef struct packed {
      gate_id_t gate;
      logic     port;
   } nbr_t;

   typedef struct packed {
      logic        wvalid;
      logic [15:0] waddr;
      logic [31:0] wdata;
   } cfg_bus_t;

endpackage

//--- verilog/logic_eval.sv
`timescale 1ns/10ps

module logic_eval import des_pkg::*; (
   input  logic_val_e p0,
   input  logic_val_e p1,
   input  gate_type_e gate,
   output logic_val_e o
);

   logic_val_e a, b;
   logic_val_e and_v, or_v, xor_v;

   function automatic logic_val_e inv(input logic_val_e v);
      logic_val_e r;
      case (v)
         LOGIC_0: r = LOGIC_1;
         LOGIC_1: r = LOGIC_0;
         default: r = LOGIC_X;
      endcase
      return r;
   endfunction

   // a floating input reads as unknown
   assign a = (p0 == LOGIC_Z) ? LOGIC_X : p0;
   assign b = (p1 == LOGIC_Z) ? LOGIC_X : p1;

   always_comb begin
      if (a == LOGIC_0 || b == LOGIC_0) and_v = LOGIC_0;
      else if (a == LOGIC_1 && b == LOGIC_1) and_v = LOGIC_1;
      else and_v = LOGIC_X;

      if (a == LOGIC_1 || b == LOGIC_1) or_v = LOGIC_1;
      else if (a == LOGIC_0 && b == LOGIC_0) or_v = LOGIC_0;
      else or_v = LOGIC_X;

      // no controlling value for xor, any unknown spreads
      if (a == LOGIC_X || b == LOGIC_X) xor_v = LOGIC_X;
      else xor_v = (a != b) ? LOGIC_1 : LOGIC_0;

      case (gate)
         BUF:     o = a;
         INV:     o = inv(a);
         NAND2:   o = inv(and_v);
         NOR2:    o = inv(or_v);
         AND2:    o = and_v;
         OR2:     o = or_v;
         XOR2:    o = xor_v;
         default: o = inv(xor_v);
      endcase
   end

endmodule

//--- verilog/des_gate_state.sv
`timescale 1ns/10ps

module des_gate_state import des_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  cfg_bus_t  cfg,
   input  logic      rd_en,
   input  gate_id_t  rd_id,
   output gate_rec_t rd_rec,
   input  logic      wr_en,
   input  gate_id_t  wr_id,
   input  gate_rec_t wr_rec
);

   gate_rec_t mem [N_GATES];

   logic      cfg_gate_wr;
   logic      mem_we;
   gate_id_t  mem_wa;
   gate_rec_t mem_wd;

   assign cfg_gate_wr = cfg.wvalid &&
                        (cfg.waddr[15:GATE_ID_W] == CFG_GATE_BASE[15:GATE_ID_W]);

   // one write port shared by the update stage and the loader
   always_comb begin
      mem_we = wr_en | cfg_gate_wr;
      mem_wa = wr_en ? wr_id : cfg.waddr[GATE_ID_W-1:0];
      mem_wd = wr_en ? wr_rec : gate_rec_t'(cfg.wdata);
   end

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_wa] <= mem_wd;
      end
      // write-first, so a back-to-back event on the same gate sees the update
      if (rd_en) begin
         rd_rec <= (mem_we && mem_wa == rd_id) ? mem_wd : mem[rd_id];
      end
   end

   a_no_write_clash : assert property (@(posedge clk) disable iff (!rstn)
      !(cfg_gate_wr && wr_en))
      else $error("configuration write collides with a record update");

endmodule

//--- verilog/des_fanout_table.sv
`timescale 1ns/10ps

module des_fanout_table import des_pkg::*; (
   input  logic                 clk,
   input  cfg_bus_t             cfg,
   input  logic                 off_rd_en,
   input  gate_id_t             off_rd_id,
   output logic [NBR_IDX_W-1:0] off_begin,
   output logic [NBR_IDX_W-1:0] off_end,
   input  logic                 nbr_rd_en,
   input  logic [NBR_IDX_W-1:0] nbr_rd_idx,
   output nbr_t                 nbr
);

   // end index in the upper half, begin index in the lower half
   logic [2*NBR_IDX_W-1:0] off_mem [N_GATES];
   nbr_t                   nbr_mem [N_NBRS];

   logic cfg_off_wr;
   logic cfg_nbr_wr;

   assign cfg_off_wr = cfg.wvalid &&
                       (cfg.waddr[15:GATE_ID_W] == CFG_OFFSET_BASE[15:GATE_ID_W]);
   assign cfg_nbr_wr = cfg.wvalid &&
                       (cfg.waddr[15:NBR_IDX_W] == CFG_NBR_BASE[15:NBR_IDX_W]);

   always_ff @(posedge clk) begin
      if (cfg_off_wr) begin
         off_mem[cfg.waddr[GATE_ID_W-1:0]] <= {cfg.wdata[16 +: NBR_IDX_W],
                                              cfg.wdata[0 +: NBR_IDX_W]};
      end
      if (off_rd_en) begin
         {off_end, off_begin} <= off_mem[off_rd_id];
      end
   end

   // neighbor word holds the gate id above the port bit
   always_ff @(posedge clk) begin
      if (cfg_nbr_wr) begin
         nbr_mem[cfg.waddr[NBR_IDX_W-1:0]] <= nbr_t'(cfg.wdata[GATE_ID_W:0]);
      end
      if (nbr_rd_en) begin
         nbr <= nbr_mem[nbr_rd_idx];
      end
   end

endmodule

//--- verilog/des_gate_update.sv
`timescale 1ns/10ps

module des_gate_update import des_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  cfg_bus_t  cfg,
   input  logic      in_valid,
   output logic      in_ready,
   input  task_t     in_task,
   output logic      rd_en,
   output gate_id_t  rd_id,
   input  gate_rec_t rd_rec,
   output logic      wr_en,
   output gate_id_t  wr_id,
   output gate_rec_t wr_rec,
   output logic      upd_valid,
   input  logic      upd_ready,
   output task_t     upd_task
);

   logic       use_seq_number;
   logic       init_done_q;
   logic       full_q;
   task_t      task_q;

   logic       is_input;
   logic       out_changed;
   logic       complete;
   logic       accept;
   logic_val_e new_in0, new_in1, new_out;
   logic [5:0] new_seq;

   assign accept   = in_valid && in_ready;
   assign is_input = (task_q.ttype == EVT_INPUT);

   // the record for the item arrives one cycle after the accept
   assign rd_en = accept && (in_task.ttype == EVT_INPUT);
   assign rd_id = in_task.locale;

   assign new_in0 = task_q.port ? rd_rec.in0_val : task_q.value;
   assign new_in1 = task_q.port ? task_q.value : rd_rec.in1_val;

   logic_eval u_eval (
      .p0   (new_in0),
      .p1   (new_in1),
      .gate (rd_rec.gtype),
      .o    (new_out)
   );

   assign out_changed = (new_out != rd_rec.out_val);

   // an unchanged output retires at once, everything else waits for the handoff
   assign upd_valid = full_q && (!is_input || out_changed);
   assign complete  = full_q && (upd_ready || (is_input && !out_changed));
   assign in_ready  = init_done_q && (!full_q || complete);

   // ~~~~~~~~~~~~~~~~~~~~
   // timestamp and record
   // ~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      upd_task = task_q;
      wr_rec   = rd_rec;
      new_seq  = 6'd0;
      if (is_input) begin
         if (use_seq_number) begin
            new_seq = rd_rec.seq + 6'd1;
            // with zero delay the sequence must not fall behind the input event
            if (new_seq < task_q.ts[5:0] && rd_rec.delay == 16'd0) begin
               new_seq = task_q.ts[5:0];
            end
            upd_task.ts = {task_q.ts[31:8] + {8'd0, rd_rec.delay}, 2'b00, new_seq};
         end else begin
            upd_task.ts = task_q.ts + {16'd0, rd_rec.delay};
         end
         upd_task.value = new_out;
         wr_rec.seq     = new_seq;
         wr_rec.out_val = new_out;
         wr_rec.in0_val = new_in0;
         wr_rec.in1_val = new_in1;
      end
   end

   assign wr_en = complete && is_input;
   assign wr_id = task_q.locale;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         init_done_q    <= 1'b0;
         full_q         <= 1'b0;
         use_seq_number <= 1'b1;
      end else begin
         init_done_q <= 1'b1;
         if (accept) full_q <= 1'b1;
         else if (complete) full_q <= 1'b0;
         if (cfg.wvalid && cfg.waddr == CFG_SEQ_EN) use_seq_number <= cfg.wdata[0];
      end
   end

   always_ff @(posedge clk) begin
      if (accept) task_q <= in_task;
   end

   a_upd_stable : assert property (@(posedge clk) disable iff (!rstn)
      upd_valid && !upd_ready |=> upd_valid && $stable(upd_task));

   a_rec_fresh : assert property (@(posedge clk) disable iff (!rstn)
      full_q && is_input && !$past(rd_en) |-> $stable(rd_rec));

   a_cfg_idle : assert property (@(posedge clk) disable iff (!rstn)
      cfg.wvalid |-> !full_q && upd_ready)
      else $error("configuration write while events are in flight");

endmodule

//--- verilog/des_fanout_reader.sv
`timescale 1ns/10ps

module des_fanout_reader import des_pkg::*; (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 upd_valid,
   output logic                 upd_ready,
   input  task_t                upd_task,
   output logic                 off_rd_en,
   output gate_id_t             off_rd_id,
   input  logic [NBR_IDX_W-1:0] off_begin,
   input  logic [NBR_IDX_W-1:0] off_end,
   output logic                 nbr_rd_en,
   output logic [NBR_IDX_W-1:0] nbr_rd_idx,
   input  nbr_t                 nbr,
   output logic                 out_valid,
   input  logic                 out_ready,
   output task_t                out_task
);

   typedef enum logic [1:0] {
      IDLE,
      READ_OFF,
      READ_NBR,
      EMIT
   } state_e;

   state_e                 state, state_nx;
   logic [NBR_IDX_W-1:0]   idx_q;
   logic [NBR_IDX_W-1:0]   end_q;
   task_t                  evt_q;

   assign upd_ready = (state == IDLE);
   assign out_valid = (state == EMIT);

   // offset lookup starts on the accept edge
   assign off_rd_en = upd_valid && upd_ready;
   assign off_rd_id = upd_task.locale;

   assign nbr_rd_en  = (state == READ_NBR);
   assign nbr_rd_idx = idx_q;

   always_comb begin
      out_task        = evt_q;
      out_task.locale = nbr.gate;
      out_task.port   = nbr.port;
      out_task.ttype  = EVT_INPUT;
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // list walk
   // ~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            if (upd_valid) state_nx = READ_OFF;
         end
         READ_OFF: begin
            state_nx = (off_begin == off_end) ? IDLE : READ_NBR;
         end
         READ_NBR: begin
            state_nx = EMIT;
         end
         EMIT: begin
            if (out_ready) state_nx = (idx_q == end_q) ? IDLE : READ_NBR;
         end
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         state <= state_nx;
      end
   end

   always_ff @(posedge clk) begin
      if (off_rd_en) evt_q <= upd_task;
      if (state == READ_OFF) begin
         idx_q <= off_begin;
         end_q <= off_end;
      end else if (nbr_rd_en) begin
         idx_q <= idx_q + NBR_IDX_W'(1);
      end
   end

   a_emit_hold : assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> state == EMIT && $stable(out_task));

endmodule

//--- verilog/des_event_tile.sv
`timescale 1ns/10ps

module des_event_tile import des_pkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  cfg_bus_t cfg,
   input  logic     in_valid,
   output logic     in_ready,
   input  task_t    in_task,
   output logic     out_valid,
   input  logic     out_ready,
   output task_t    out_task
);

   logic                 rd_en;
   gate_id_t             rd_id;
   gate_rec_t            rd_rec;
   logic                 wr_en;
   gate_id_t             wr_id;
   gate_rec_t            wr_rec;

   logic                 upd_valid;
   logic                 upd_ready;
   task_t                upd_task;

   logic                 off_rd_en;
   gate_id_t             off_rd_id;
   logic [NBR_IDX_W-1:0] off_begin;
   logic [NBR_IDX_W-1:0] off_end;
   logic                 nbr_rd_en;
   logic [NBR_IDX_W-1:0] nbr_rd_idx;
   nbr_t                 nbr;

   des_gate_update u_update (
      .clk       (clk),
      .rstn      (rstn),
      .cfg       (cfg),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_task   (in_task),
      .rd_en     (rd_en),
      .rd_id     (rd_id),
      .rd_rec    (rd_rec),
      .wr_en     (wr_en),
      .wr_id     (wr_id),
      .wr_rec    (wr_rec),
      .upd_valid (upd_valid),
      .upd_ready (upd_ready),
      .upd_task  (upd_task)
   );

   des_gate_state u_state (
      .clk    (clk),
      .rstn   (rstn),
      .cfg    (cfg),
      .rd_en  (rd_en),
      .rd_id  (rd_id),
      .rd_rec (rd_rec),
      .wr_en  (wr_en),
      .wr_id  (wr_id),
      .wr_rec (wr_rec)
   );

   des_fanout_table u_table (
      .clk        (clk),
      .cfg        (cfg),
      .off_rd_en  (off_rd_en),
      .off_rd_id  (off_rd_id),
      .off_begin  (off_begin),
      .off_end    (off_end),
      .nbr_rd_en  (nbr_rd_en),
      .nbr_rd_idx (nbr_rd_idx),
      .nbr        (nbr)
   );

   des_fanout_reader u_reader (
      .clk        (clk),
      .rstn       (rstn),
      .upd_valid  (upd_valid),
      .upd_ready  (upd_ready),
      .upd_task   (upd_task),
      .off_rd_en  (off_rd_en),
      .off_rd_id  (off_rd_id),
      .off_begin  (off_begin),
      .off_end    (off_end),
      .nbr_rd_en  (nbr_rd_en),
      .nbr_rd_idx (nbr_rd_idx),
      .nbr        (nbr),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_task   (out_task)
   );

endmodule

//--- tb/des_event_tile_tb.sv
`timescale 1ns/10ps

module des_event_tile_tb import des_pkg::*; ();

   localparam int N_TB_GATES   = 12;
   localparam int ACCEPT_LIMIT = 200;
   localparam int DRAIN_LIMIT  = 2000;
   localparam int QUIET        = 10;

   typedef struct packed {
      task_t          evt;
      logic           seq_mode;
      logic           chain;
      logic [2:0]     n_exp;
      task_t [3:0]    kids;
   } entry_t;

   logic     clk;
   logic     rstn;
   cfg_bus_t cfg;
   logic     in_valid;
   logic     in_ready;
   task_t    in_task;
   logic     out_valid;
   logic     out_ready = 1'b0;
   task_t    out_task;

   gate_rec_t            model_rec [N_TB_GATES];
   logic [NBR_IDX_W-1:0] off_b [N_TB_GATES];
   logic [NBR_IDX_W-1:0] off_e [N_TB_GATES];
   nbr_t                 nbr_tab [48];
   entry_t               table_q [$];
   task_t                exp_q [$];
   bit                   ready_pat [256];
   logic [7:0]           ready_cyc = 8'd0;
   int                   errors = 0;
   int                   rx_count = 0;
   bit                   timed_out = 1'b0;

   des_event_tile uut (
      .clk       (clk),
      .rstn      (rstn),
      .cfg       (cfg),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_task   (in_task),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_task  (out_task)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // back-pressure pattern is drawn up front and replayed cyclically
   always @(negedge clk) begin
      out_ready = ready_pat[ready_cyc];
      ready_cyc = ready_cyc + 8'd1;
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // compare tasks
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic check_task(input task_t got, input task_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s got ts %h gate %0d port %0d val %0d type %0d",
                  $time, what, got.ts, got.locale, got.port, got.value, got.ttype);
         $display("     expected ts %h gate %0d port %0d val %0d type %0d",
                  exp.ts, exp.locale, exp.port, exp.value, exp.ttype);
         errors++;
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("FAIL %0t: %s got %0d children, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_rec(input gate_rec_t got, input gate_rec_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // the testbench plays the scheduler and takes every child
   always @(posedge clk) begin
      if (rstn && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("FAIL %0t: unexpected child for gate %0d", $time, out_task.locale);
            errors++;
         end else begin
            check_task(out_task, exp_q.pop_front(), "child");
         end
         rx_count++;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // reference model
   // ~~~~~~~~~~~~~~~~~~~~

   function automatic logic_val_e gate_out_ref(input gate_type_e t, input logic_val_e x,
                                               input logic_val_e y);
      logic_val_e a, b, r;
      logic       neg;
      a = (x == LOGIC_Z) ? LOGIC_X : x;
      b = (y == LOGIC_Z) ? LOGIC_X : y;
      neg = (t == INV || t == NAND2 || t == NOR2 || t == XNOR2);
      case (t)
         BUF, INV:    r = a;
         AND2, NAND2: r = (a == LOGIC_0 || b == LOGIC_0) ? LOGIC_0 :
                          (a == LOGIC_X || b == LOGIC_X) ? LOGIC_X : LOGIC_1;
         OR2, NOR2:   r = (a == LOGIC_1 || b == LOGIC_1) ? LOGIC_1 :
                          (a == LOGIC_X || b == LOGIC_X) ? LOGIC_X : LOGIC_0;
         default:     r = (a == LOGIC_X || b == LOGIC_X) ? LOGIC_X :
                          (a == b) ? LOGIC_0 : LOGIC_1;
      endcase
      if (neg && r != LOGIC_X) r = (r == LOGIC_0) ? LOGIC_1 : LOGIC_0;
      return r;
   endfunction

   task automatic predict_entry(inout entry_t e);
      gate_rec_t   r;
      task_t       c;
      logic_val_e  i0, i1, o;
      logic [5:0]  sq;
      logic [31:0] ts_o;
      logic        emit;
      int          g, k, n;
      g = int'(e.evt.locale);
      r = model_rec[g];
      n = 0;
      e.kids = '0;
      if (e.evt.ttype == EVT_BROADCAST) begin
         o    = e.evt.value;
         ts_o = e.evt.ts;
         emit = 1'b1;
      end else begin
         i0 = e.evt.port ? r.in0_val : e.evt.value;
         i1 = e.evt.port ? e.evt.value : r.in1_val;
         o = gate_out_ref(r.gtype, i0, i1);
         emit = (o != r.out_val);
         if (e.seq_mode) begin
            sq = r.seq + 6'd1;
            if (r.delay == 16'd0 && sq < e.evt.ts[5:0]) sq = e.evt.ts[5:0];
            ts_o = {e.evt.ts[31:8] + {8'h00, r.delay}, 2'b00, sq};
         end else begin
            sq = 6'd0;
            ts_o = e.evt.ts + {16'h0000, r.delay};
         end
         r.seq = sq;
         r.out_val = o;
         r.in0_val = i0;
         r.in1_val = i1;
         model_rec[g] = r;
      end
      if (emit) begin
         for (k = int'(off_b[g]); k < int'(off_e[g]); k++) begin
            c.ts = ts_o;
            c.locale = nbr_tab[k].gate;
            c.port = nbr_tab[k].port;
            c.value = o;
            c.ttype = EVT_INPUT;
            e.kids[n] = c;
            n++;
         end
      end
      e.n_exp = 3'(n);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic cfg_write(input logic [15:0] addr, input logic [31:0] data);
      cfg.wvalid = 1'b1;
      cfg.waddr = addr;
      cfg.wdata = data;
      @(negedge clk);
   endtask

   task automatic load_netlist();
      gate_rec_t r;
      int        g, k, idx, n;
      idx = 0;
      for (g = 0; g < N_TB_GATES; g++) begin
         r = '0;
         r.seq = 6'(60 + g);
         r.out_val = LOGIC_X;
         r.in0_val = LOGIC_X;
         r.in1_val = LOGIC_X;
         case (g)
            8:       r.gtype = AND2;
            9:       r.gtype = BUF;
            10:      r.gtype = OR2;
            11:      r.gtype = XOR2;
            default: r.gtype = gate_type_e'(g[2:0]);
         endcase
         // every third gate has zero delay so the sequence clamp gets exercised
         r.delay = (g % 3 == 0) ? 16'd0 : 16'(100 * g + 7);
         model_rec[g] = r;
         cfg_write(CFG_GATE_BASE + 16'(g), r);
         n = (g == 8) ? 0 : g % 4 + 1;
         off_b[g] = NBR_IDX_W'(idx);
         for (k = 0; k < n; k++) begin
            nbr_tab[idx].gate = gate_id_t'((g + 1 + 3 * k) % N_TB_GATES);
            nbr_tab[idx].port = k[0];
            cfg_write(CFG_NBR_BASE + 16'(idx), {21'd0, nbr_tab[idx]});
            idx++;
         end
         off_e[g] = NBR_IDX_W'(idx);
         cfg_write(CFG_OFFSET_BASE + 16'(g), {4'd0, off_e[g], 4'd0, off_b[g]});
      end
      cfg.wvalid = 1'b0;
   endtask

   task automatic add_entry(input int g, input task_type_e tt, input logic p, input int v,
                            input logic mode, input logic chain);
      entry_t e;
      e = '0;
      e.evt.ts = $urandom;
      e.evt.locale = gate_id_t'(g);
      e.evt.ttype = tt;
      e.evt.port = p;
      e.evt.value = logic_val_e'(v[1:0]);
      e.seq_mode = mode;
      e.chain = chain;
      table_q.push_back(e);
   endtask

   task automatic build_table();
      int g, a, b, j;
      // all sixteen input pairs per gate type, port 0 held while port 1 sweeps
      for (g = 0; g < 8; g++) begin
         for (a = 0; a < 4; a++) begin
            add_entry(g, EVT_INPUT, 1'b0, a, 1'b1, 1'b0);
            for (b = 0; b < 4; b++) add_entry(g, EVT_INPUT, 1'b1, b, 1'b1, 1'b0);
         end
      end
      add_entry(8, EVT_INPUT, 1'b0, 1, 1'b1, 1'b0);
      add_entry(8, EVT_INPUT, 1'b1, 1, 1'b1, 1'b0);
      add_entry(8, EVT_INPUT, 1'b0, 0, 1'b1, 1'b0);
      for (a = 0; a < 4; a++) add_entry(9, EVT_BROADCAST, 1'b0, a, 1'b1, 1'b0);
      for (j = 0; j < 8; j++) begin
         g = int'($urandom % 8);
         add_entry(g, EVT_INPUT, 1'b0, int'($urandom % 4), 1'b1, 1'b1);
         add_entry(g, EVT_INPUT, 1'b1, int'($urandom % 4), 1'b1, 1'b0);
      end
      // plain timestamp format
      for (j = 0; j < 10; j++) begin
         g = int'($urandom % 8);
         add_entry(g, EVT_INPUT, 1'b0, int'($urandom % 4), 1'b0, 1'b1);
         add_entry(g, EVT_INPUT, 1'b1, int'($urandom % 4), 1'b0, 1'b0);
      end
      for (j = 0; j < 8; j++) begin
         add_entry(int'($urandom % 8), EVT_INPUT, j[0], int'($urandom % 4), 1'b0, 1'b0);
      end
      add_entry(9, EVT_BROADCAST, 1'b0, 1, 1'b0, 1'b0);
      add_entry(3, EVT_INPUT, 1'b0, int'($urandom % 4), 1'b1, 1'b0);
      add_entry(3, EVT_INPUT, 1'b1, int'($urandom % 4), 1'b1, 1'b0);
   endtask

   task automatic send_event(input task_t t, input int idx);
      int n;
      bit done;
      in_valid = 1'b1;
      in_task = t;
      n = 0;
      done = 1'b0;
      while (!done && n < ACCEPT_LIMIT) begin
         @(posedge clk);
         done = in_ready;
         n++;
      end
      @(negedge clk);
      in_valid = 1'b0;
      if (!done) begin
         $display("timeout: entry %0d was not accepted within %0d cycles", idx, ACCEPT_LIMIT);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_drain(input int idx);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: %0d children up to entry %0d never came out", exp_q.size(), idx);
         timed_out = 1'b1;
      end
   endtask

   initial begin
      entry_t e;
      int     i, k, g, pend, rx_base, n_exp_total;
      logic   cur_mode;
      rstn = 1'b0;
      in_valid = 1'b0;
      in_task = '0;
      cfg = '0;
      void'($urandom(32'h57c6));
      for (i = 0; i < 256; i++) ready_pat[i] = ($urandom % 4) != 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      load_netlist();
      build_table();
      for (i = 0; i < table_q.size(); i++) begin
         e = table_q[i];
         predict_entry(e);
         table_q[i] = e;
      end

      cur_mode = 1'b1;
      pend = 0;
      rx_base = 0;
      n_exp_total = 0;
      for (i = 0; i < table_q.size() && !timed_out; i++) begin
         e = table_q[i];
         // mode changes only between drained entries, while the tile is idle
         if (e.seq_mode != cur_mode) begin
            cfg_write(CFG_SEQ_EN, {31'd0, e.seq_mode});
            cfg.wvalid = 1'b0;
            cur_mode = e.seq_mode;
         end
         for (k = 0; k < int'(e.n_exp); k++) exp_q.push_back(e.kids[k]);
         pend += int'(e.n_exp);
         n_exp_total += int'(e.n_exp);
         send_event(e.evt, i);
         if (!timed_out && e.chain) begin
            $display("entry %0d: gate %0d accepted, checked with the next entry",
                     i, e.evt.locale);
         end else if (!timed_out) begin
            wait_drain(i);
            repeat (QUIET) @(negedge clk);
            check_count(rx_count - rx_base, pend, $sformatf("entry %0d", i));
            $display("entry %0d: gate %0d type %0d port %0d value %0d, %0d children",
                     i, e.evt.locale, e.evt.ttype, e.evt.port, e.evt.value, rx_count - rx_base);
            rx_base = rx_count;
            pend = 0;
         end
      end

      if (!timed_out) begin
         for (g = 0; g < N_TB_GATES; g++) begin
            check_rec(uut.u_state.mem[g], model_rec[g], $sformatf("gate %0d record", g));
         end
      end

      $display("entries %0d, children %0d of %0d, errors %0d",
               table_q.size(), rx_count, n_exp_total, errors);
      if (errors == 0 && !timed_out) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
verilog/des_pkg.sv
verilog/logic_eval.sv
verilog/des_gate_state.sv
verilog/des_fanout_table.sv
verilog/des_gate_update.sv
verilog/des_fanout_reader.sv
verilog/des_event_tile.sv
tb/des_event_tile_tb.sv

//--- run.sh
#!/bin/sh
# builds the event tile testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module des_event_tile_tb -Mdir obj_dir -o des_event_tile_sim -f flist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/des_event_tile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
